// File: rtl/boot_pkg.sv
package boot_pkg;

  // ========================================================================
  // Widths with a meaning
  // ========================================================================

  // Word address into the boot RAM, only the low bits are decoded
  typedef logic [15:0] addr_t;

  // One RAM data word
  typedef logic [31:0] word_t;

  // One received serial byte
  typedef logic [7:0] byte_t;

  // ========================================================================
  // Bus between requesters, arbiter and RAM
  // ========================================================================

  // Request payload, qualified by a separate req bit
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } bus_req_t;

  // Response payload, valid while ack is high
  typedef struct packed {
    word_t rdata;
  } bus_rsp_t;

  // ========================================================================
  // Boot sequence
  // ========================================================================

  // Number of bytes in the magic window
  localparam int unsigned MAGIC_LEN = 8;

  // "BOOTLOAD", first received byte in the top byte lane
  localparam logic [MAGIC_LEN*8-1:0] MAGIC_SEQ = 64'h424F_4F54_4C4F_4144;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx
  import boot_pkg::*;
#(
  parameter int unsigned CLKS_PER_BIT = 16
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  rx_i,
  output byte_t byte_o,
  output logic  valid_o
);

  localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_t;

  state_t state_q;

  // Two-flop synchronizer plus one flop for edge detection
  logic rx_meta_q;
  logic rx_sync_q;
  logic rx_prev_q;

  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  byte_t            shift_q;
  logic             valid_q;

  logic start_edge;
  logic half_bit;
  logic full_bit;

  // Falling edge of the line while idle marks a start bit
  assign start_edge = rx_prev_q && !rx_sync_q;
  assign half_bit   = (clk_cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
  assign full_bit   = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  // ========================================================================
  // Line synchronizer
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      // Line idles high
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  // ========================================================================
  // Bit timing and framing FSM
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (start_edge) state_q <= ST_START;
        end
        ST_START: begin
          // Recheck the start bit at its middle, reject glitches
          if (half_bit) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? ST_IDLE : ST_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (full_bit) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            // Eighth data bit done
            if (bit_idx_q == 3'd7) state_q <= ST_STOP;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_STOP: begin
          if (full_bit) begin
            clk_cnt_q <= '0;
            // Low stop bit means a framing error, byte is dropped
            valid_q   <= rx_sync_q;
            state_q   <= ST_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == ST_DATA && full_bit) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o  = shift_q;
  assign valid_o = valid_q;

endmodule

// File: rtl/ram_programmer.sv
`timescale 1ns/10ps

module ram_programmer
  import boot_pkg::*;
#(
  parameter int unsigned BREAK_CYCLES = 1000,
  parameter int unsigned MEM_DEPTH    = 1024
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  byte_t    rx_byte_i,
  input  logic     rx_valid_i,
  output logic     req_o,
  output bus_req_t req_o_bus,
  input  logic     ack_i,
  output logic     prog_mode_o,
  output logic     sys_rst_no
);

  localparam int unsigned BRK_W = $clog2(BREAK_CYCLES + 1);
  localparam int unsigned WIN_W = MAGIC_LEN * 8;

  typedef enum logic [2:0] {
    ST_HUNT,
    ST_COUNT,
    ST_LOAD,
    ST_WAIT_ACK,
    ST_WAIT_REL,
    ST_FINISH
  } state_t;

  state_t state_q;
  state_t state_d;

  // Magic detection
  logic [WIN_W-1:0] window_q;
  logic             shifted_q;
  logic [BRK_W-1:0] break_cnt_q;

  // Count and word assembly
  logic [1:0] byte_cnt_q;
  word_t      count_q;
  word_t      word_idx_q;
  word_t      word_buf_q;
  addr_t      next_addr_q;

  // Held write request
  word_t wr_data_q;
  addr_t wr_addr_q;

  logic  seq_match;
  logic  brk_expired;
  logic  load_active;
  logic  byte_take;
  logic  count_done;
  logic  word_done;
  logic  last_word;
  word_t count_next;
  word_t word_next;

  // ========================================================================
  // Decode
  // ========================================================================

  // Compare only on the cycle after a byte entered the window
  assign seq_match   = (state_q == ST_HUNT) && shifted_q && (window_q == MAGIC_SEQ);
  assign brk_expired = (break_cnt_q == BRK_W'(BREAK_CYCLES - 1));

  // Bytes keep arriving during the handshake, so assembly runs in all load states
  assign load_active = (state_q inside {ST_LOAD, ST_WAIT_ACK, ST_WAIT_REL}) &&
                       (word_idx_q != count_q);
  assign byte_take   = rx_valid_i && ((state_q == ST_COUNT) || load_active);
  assign count_done  = rx_valid_i && (state_q == ST_COUNT) && (byte_cnt_q == 2'd3);
  assign word_done   = rx_valid_i && load_active && (byte_cnt_q == 2'd3);
  assign last_word   = (word_idx_q == count_q);

  // Count is MSB first, words are LSB first
  assign count_next  = {count_q[23:0], rx_byte_i};
  assign word_next   = {rx_byte_i, word_buf_q[31:8]};

  // ========================================================================
  // Next state
  // ========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_HUNT: begin
        if (seq_match) state_d = ST_COUNT;
      end
      ST_COUNT: begin
        // Empty image goes straight to the reset pulse
        if (count_done) state_d = (count_next == '0) ? ST_FINISH : ST_LOAD;
      end
      ST_LOAD: begin
        if (word_done) state_d = ST_WAIT_ACK;
      end
      ST_WAIT_ACK: begin
        if (ack_i) state_d = ST_WAIT_REL;
      end
      ST_WAIT_REL: begin
        // Four-phase done once ack is low again
        if (!ack_i) state_d = last_word ? ST_FINISH : ST_LOAD;
      end
      ST_FINISH: state_d = ST_HUNT;
      default:   state_d = ST_HUNT;
    endcase
  end

  // ========================================================================
  // Control registers
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= ST_HUNT;
      window_q    <= '0;
      shifted_q   <= 1'b0;
      break_cnt_q <= '0;
      byte_cnt_q  <= '0;
      word_idx_q  <= '0;
      next_addr_q <= '0;
    end else begin
      state_q <= state_d;

      // Sliding window with inter-byte timeout
      if (state_q != ST_HUNT || seq_match) begin
        window_q    <= '0;
        shifted_q   <= 1'b0;
        break_cnt_q <= '0;
      end else if (rx_valid_i) begin
        window_q    <= {window_q[WIN_W-9:0], rx_byte_i};
        shifted_q   <= 1'b1;
        break_cnt_q <= '0;
      end else begin
        shifted_q <= 1'b0;
        if (brk_expired) begin
          // Line went quiet mid sequence
          window_q    <= '0;
          break_cnt_q <= '0;
        end else begin
          break_cnt_q <= break_cnt_q + 1'b1;
        end
      end

      // Byte lane and word index, restarted by every match
      if (seq_match) begin
        byte_cnt_q  <= '0;
        word_idx_q  <= '0;
        next_addr_q <= '0;
      end else begin
        if (byte_take) byte_cnt_q <= byte_cnt_q + 1'b1;
        if (word_done) begin
          word_idx_q <= word_idx_q + 1'b1;
          // Addresses wrap at the RAM depth
          if (next_addr_q == addr_t'(MEM_DEPTH - 1)) next_addr_q <= '0;
          else next_addr_q <= next_addr_q + 1'b1;
        end
      end
    end
  end

  // ========================================================================
  // Payload registers
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (rx_valid_i && state_q == ST_COUNT) count_q <= count_next;
    if (byte_take && load_active) word_buf_q <= word_next;
    // Capture finished word, held stable until the handshake ends
    if (word_done) begin
      wr_data_q <= word_next;
      wr_addr_q <= next_addr_q;
    end
  end

  // ========================================================================
  // Outputs
  // ========================================================================
  assign req_o           = (state_q == ST_WAIT_ACK);
  assign req_o_bus.we    = 1'b1;
  assign req_o_bus.addr  = wr_addr_q;
  assign req_o_bus.wdata = wr_data_q;

  // Programming window ends on the reset pulse cycle
  assign prog_mode_o = state_q inside {ST_COUNT, ST_LOAD, ST_WAIT_ACK, ST_WAIT_REL};
  assign sys_rst_no  = (state_q != ST_FINISH);

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
  import boot_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic     [1:0] req_i,
  input  bus_req_t [1:0] bus_i,
  output logic     [1:0] ack_o,
  output bus_rsp_t       rsp_o,
  output logic           mem_en_o,
  output logic           mem_we_o,
  output addr_t          mem_addr_o,
  output word_t          mem_wdata_o,
  input  word_t          mem_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_ACK
  } state_t;

  state_t state_q;

  logic  grant_q;
  logic  last_q;
  logic  pick;
  word_t rdata_q;

  // ========================================================================
  // Port selection
  // ========================================================================

  // Tie goes to the port not served last, otherwise whoever asks
  assign pick = (req_i == 2'b11) ? ~last_q : req_i[1];

  // RAM access issued at the grant edge
  assign mem_en_o    = (state_q == ST_IDLE) && (|req_i);
  assign mem_we_o    = bus_i[pick].we;
  assign mem_addr_o  = bus_i[pick].addr;
  assign mem_wdata_o = bus_i[pick].wdata;

  // ========================================================================
  // Grant FSM
  // ========================================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      grant_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|req_i) begin
            grant_q <= pick;
            last_q  <= pick;
            state_q <= ST_ACCESS;
          end
        end
        // Read data arrives during this cycle
        ST_ACCESS: state_q <= ST_ACK;
        ST_ACK: begin
          // Hold grant until the owner releases req
          if (!req_i[grant_q]) state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_ACCESS) rdata_q <= mem_rdata_i;
  end

  assign ack_o[0]    = (state_q == ST_ACK) && !grant_q;
  assign ack_o[1]    = (state_q == ST_ACK) && grant_q;
  assign rsp_o.rdata = rdata_q;

endmodule

// File: rtl/boot_ram.sv
`timescale 1ns/10ps

module boot_ram
  import boot_pkg::*;
#(
  parameter int unsigned MEM_DEPTH = 1024
) (
  input  logic  clk_i,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  // Index width, at least one bit
  localparam int unsigned AW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  word_t         mem_q [MEM_DEPTH];
  logic [AW-1:0] idx;

  // Upper address bits are not decoded
  assign idx = addr_i[AW-1:0];

  // Registered read, a write returns the previous word
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) mem_q[idx] <= wdata_i;
      rdata_o <= mem_q[idx];
    end
  end

endmodule

// File: rtl/boot_top.sv
`timescale 1ns/10ps

module boot_top
  import boot_pkg::*;
#(
  parameter int unsigned CLKS_PER_BIT = 16,
  parameter int unsigned BREAK_CYCLES = 1000,
  parameter int unsigned MEM_DEPTH    = 1024
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     uart_rx_i,
  input  logic     host_req_i,
  input  bus_req_t host_bus_i,
  output logic     host_ack_o,
  output bus_rsp_t host_rsp_o,
  output logic     prog_mode_o,
  output logic     sys_rst_no
);

  // Receiver to loader
  byte_t rx_byte;
  logic  rx_valid;

  // Requester side of the arbiter, port 0 loader, port 1 host
  logic           prog_req;
  bus_req_t       prog_bus;
  logic     [1:0] arb_req;
  logic     [1:0] arb_ack;
  bus_req_t [1:0] arb_bus;
  bus_rsp_t       arb_rsp;

  // Arbiter to RAM
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  assign arb_req    = {host_req_i, prog_req};
  assign arb_bus    = {host_bus_i, prog_bus};
  assign host_ack_o = arb_ack[1];
  assign host_rsp_o = arb_rsp;

  // ========================================================================
  // Serial receive and loader
  // ========================================================================
  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rx_i   (uart_rx_i),
    .byte_o (rx_byte),
    .valid_o(rx_valid)
  );

  ram_programmer #(
    .BREAK_CYCLES(BREAK_CYCLES),
    .MEM_DEPTH   (MEM_DEPTH)
  ) u_ram_programmer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .req_o      (prog_req),
    .req_o_bus  (prog_bus),
    .ack_i      (arb_ack[0]),
    .prog_mode_o(prog_mode_o),
    .sys_rst_no (sys_rst_no)
  );

  // ========================================================================
  // Shared RAM
  // ========================================================================
  mem_arbiter u_mem_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (arb_req),
    .bus_i      (arb_bus),
    .ack_o      (arb_ack),
    .rsp_o      (arb_rsp),
    .mem_en_o   (mem_en),
    .mem_we_o   (mem_we),
    .mem_addr_o (mem_addr),
    .mem_wdata_o(mem_wdata),
    .mem_rdata_i(mem_rdata)
  );

  boot_ram #(
    .MEM_DEPTH(MEM_DEPTH)
  ) u_boot_ram (
    .clk_i  (clk_i),
    .en_i   (mem_en),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

endmodule

// File: dv/boot_props.sv
`timescale 1ns/10ps

module boot_props
  import boot_pkg::*;
(
  input logic           clk_i,
  input logic           rst_ni,
  input logic     [1:0] req_i,
  input logic     [1:0] ack_i,
  input bus_req_t [1:0] bus_i,
  input logic           word_done_i
);

  // ==========================================================================
  // Four-phase handshake
  // ==========================================================================

  // Ack only toward a port that asks
  ack_after_req_0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i[0]) |-> $past(req_i[0])) else $error("ack 0 rose without req");
  ack_after_req_1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_i[1]) |-> $past(req_i[1])) else $error("ack 1 rose without req");

  // Req only released once acked
  req_hold_0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(req_i[0]) |-> ack_i[0]) else $error("req 0 dropped before ack");
  req_hold_1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(req_i[1]) |-> ack_i[1]) else $error("req 1 dropped before ack");

  // Payload frozen while waiting
  bus_stable_0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i[0] && !ack_i[0] |=> $stable(bus_i[0])) else $error("bus 0 changed under req");
  bus_stable_1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i[1] && !ack_i[1] |=> $stable(bus_i[1])) else $error("bus 1 changed under req");

  // Loader never finishes a word mid handshake
  no_word_in_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i[0] |-> !word_done_i) else $error("word completed while loader req high");

endmodule

bind mem_arbiter boot_props u_arb_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .bus_i      (bus_i),
  .word_done_i(1'b0)
);

bind ram_programmer boot_props u_prog_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .req_i      ({1'b0, req_o}),
  .ack_i      ({1'b0, ack_i}),
  .bus_i      ({req_o_bus, req_o_bus}),
  .word_done_i(word_done)
);

// File: dv/tb_boot_top.sv
`timescale 1ns/10ps

module tb_boot_top
  import boot_pkg::*;
();

  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BREAK_CYCLES = 400;
  localparam int unsigned MEM_DEPTH    = 64;
  // Limits for the handshake and done waits
  localparam int unsigned HS_TIMEOUT   = 100;
  localparam int unsigned DONE_TIMEOUT = 2000;

  logic     clk;
  logic     rst_n;
  logic     uart_rx;
  logic     host_req;
  bus_req_t host_bus;
  logic     host_ack;
  bus_rsp_t host_rsp;
  logic     prog_mode;
  logic     sys_rst_n;

  // Reference image and the words of the current load
  word_t exp_mem [MEM_DEPTH];
  word_t load_words [$];

  int unsigned err_count      = 0;
  int unsigned check_count    = 0;
  int unsigned test_count     = 0;
  int unsigned test_err_base  = 0;
  // Running totals, tests compare against a snapshot
  int unsigned rst_low_cycles = 0;
  int unsigned prog_cycles    = 0;

  boot_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .BREAK_CYCLES(BREAK_CYCLES),
    .MEM_DEPTH   (MEM_DEPTH)
  ) uut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .uart_rx_i  (uart_rx),
    .host_req_i (host_req),
    .host_bus_i (host_bus),
    .host_ack_o (host_ack),
    .host_rsp_o (host_rsp),
    .prog_mode_o(prog_mode),
    .sys_rst_no (sys_rst_n)
  );

  always #5 clk = ~clk;

  // Output monitor on the falling edge, away from DUT updates
  always @(negedge clk) begin
    if (rst_n) begin
      if (!sys_rst_n) rst_low_cycles <= rst_low_cycles + 1;
      if (prog_mode) prog_cycles <= prog_cycles + 1;
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic abort_run(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic check_eq(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, name,
             err_count - test_err_base);
    test_err_base = err_count;
  endtask

  // 8N1 frame, LSB first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  // Magic and count MSB first, words LSB first
  task automatic send_load(input logic [63:0] magic, input word_t count);
    for (int i = MAGIC_LEN - 1; i >= 0; i--) send_byte(magic[i*8 +: 8]);
    for (int i = 3; i >= 0; i--) send_byte(count[i*8 +: 8]);
    for (int n = 0; n < load_words.size(); n++) begin
      for (int i = 0; i < 4; i++) send_byte(load_words[n][i*8 +: 8]);
    end
  endtask

  task automatic make_words(input int unsigned num);
    load_words.delete();
    repeat (num) load_words.push_back($urandom());
  endtask

  // Four-phase access on the host port
  task automatic host_access(input logic we, input addr_t addr, input word_t wdata,
                             output word_t rdata);
    int unsigned cycles;
    host_bus.we    = we;
    host_bus.addr  = addr;
    host_bus.wdata = wdata;
    host_req       = 1'b1;
    cycles         = 0;
    @(negedge clk);
    while (!host_ack) begin
      if (cycles == HS_TIMEOUT) abort_run("host ack never rose");
      @(negedge clk);
      cycles++;
    end
    rdata    = host_rsp.rdata;
    host_req = 1'b0;
    cycles   = 0;
    @(negedge clk);
    while (host_ack) begin
      if (cycles == HS_TIMEOUT) abort_run("host ack never fell");
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    word_t unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic host_read(input addr_t addr, output word_t data);
    host_access(1'b0, addr, '0, data);
  endtask

  task automatic wait_reset_pulse(input int unsigned base);
    int unsigned cycles;
    cycles = 0;
    while (rst_low_cycles == base) begin
      if (cycles == DONE_TIMEOUT) abort_run("no sys_rst_no pulse after the load");
      @(negedge clk);
      cycles++;
    end
    // Room for a pulse that is too wide
    repeat (4) @(negedge clk);
  endtask

  // ==========================================================================
  // Reference model
  // ==========================================================================

  // Word n lands at n mod depth, later words win, bad magic changes nothing
  function automatic word_t ref_word(input logic [63:0] magic, input int unsigned count,
                                     input int unsigned addr, input word_t prior);
    word_t result;
    result = prior;
    if (magic == MAGIC_SEQ) begin
      for (int unsigned n = 0; n < count; n++) begin
        if (n % MEM_DEPTH == addr) result = load_words[n];
      end
    end
    return result;
  endfunction

  task automatic apply_load(input logic [63:0] magic, input int unsigned count);
    for (int unsigned a = 0; a < MEM_DEPTH; a++) begin
      exp_mem[a] = ref_word(magic, count, a, exp_mem[a]);
    end
  endtask

  // Read back every word and compare with the reference
  task automatic compare_image(input string what);
    word_t rd;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      host_read(addr_t'(a), rd);
      check_eq($sformatf("%s addr %0d", what, a), rd, exp_mem[a]);
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    word_t       rd;
    word_t       hw;
    int unsigned rst_base;
    int unsigned prog_base;
    logic [63:0] bad_magic;
    void'($urandom(27628));
    clk      = 1'b0;
    rst_n    = 1'b0;
    uart_rx  = 1'b1;
    host_req = 1'b0;
    host_bus = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Reset values, then a known image through the host port
    check_eq("prog_mode after reset", 32'(prog_mode), 32'd0);
    check_eq("sys_rst_n after reset", 32'(sys_rst_n), 32'd1);
    check_eq("host_ack after reset", 32'(host_ack), 32'd0);
    for (int a = 0; a < MEM_DEPTH; a++) begin
      hw = {~16'(a), 16'(a)};
      host_write(addr_t'(a), hw);
      exp_mem[a] = hw;
    end
    compare_image("fill");
    end_test("reset and fill");

    // Plain valid load
    make_words(16);
    rst_base  = rst_low_cycles;
    prog_base = prog_cycles;
    send_load(MAGIC_SEQ, 32'd16);
    wait_reset_pulse(rst_base);
    apply_load(MAGIC_SEQ, 16);
    compare_image("valid load");
    check_eq("prog_mode raised", 32'(prog_cycles != prog_base), 32'd1);
    check_eq("reset pulse cycles", rst_low_cycles - rst_base, 32'd1);
    end_test("valid load");

    // Last magic byte wrong
    bad_magic = {MAGIC_SEQ[63:8], 8'h58};
    make_words(8);
    rst_base  = rst_low_cycles;
    prog_base = prog_cycles;
    send_load(bad_magic, 32'd8);
    apply_load(bad_magic, 8);
    compare_image("wrong magic");
    check_eq("prog_mode stayed low", prog_cycles - prog_base, 32'd0);
    check_eq("no reset pulse", rst_low_cycles - rst_base, 32'd0);
    end_test("wrong magic");

    // Seven magic bytes, a long quiet line, the lone last byte, then a full load
    make_words(8);
    rst_base = rst_low_cycles;
    for (int i = MAGIC_LEN - 1; i >= 1; i--) send_byte(MAGIC_SEQ[i*8 +: 8]);
    repeat (BREAK_CYCLES + 40) @(negedge clk);
    // Would complete the stale window if it survived the gap
    send_byte(MAGIC_SEQ[7:0]);
    send_load(MAGIC_SEQ, 32'd8);
    wait_reset_pulse(rst_base);
    apply_load(MAGIC_SEQ, 8);
    compare_image("break then load");
    check_eq("reset pulse cycles", rst_low_cycles - rst_base, 32'd1);
    end_test("partial magic and break");

    // Host traffic competing with loader writes
    make_words(8);
    rst_base = rst_low_cycles;
    fork
      send_load(MAGIC_SEQ, 32'd8);
      begin
        // Host writes to 4..7 land first and get overwritten
        for (int a = 4; a < 8; a++) begin
          hw = $urandom();
          host_write(addr_t'(a), hw);
          exp_mem[a] = hw;
        end
        for (int a = 40; a < 44; a++) begin
          hw = $urandom();
          host_write(addr_t'(a), hw);
          exp_mem[a] = hw;
        end
        repeat (150) begin
          for (int a = 40; a < 44; a++) begin
            host_read(addr_t'(a), rd);
            check_eq($sformatf("read during load addr %0d", a), rd, exp_mem[a]);
          end
        end
      end
    join
    wait_reset_pulse(rst_base);
    apply_load(MAGIC_SEQ, 8);
    compare_image("shared load");
    check_eq("reset pulse cycles", rst_low_cycles - rst_base, 32'd1);
    end_test("host traffic during load");

    // Empty image, then more words than the RAM holds
    load_words.delete();
    rst_base = rst_low_cycles;
    send_load(MAGIC_SEQ, 32'd0);
    wait_reset_pulse(rst_base);
    apply_load(MAGIC_SEQ, 0);
    compare_image("zero count");
    check_eq("zero count pulse cycles", rst_low_cycles - rst_base, 32'd1);
    make_words(MEM_DEPTH + 6);
    rst_base = rst_low_cycles;
    send_load(MAGIC_SEQ, word_t'(MEM_DEPTH + 6));
    wait_reset_pulse(rst_base);
    apply_load(MAGIC_SEQ, MEM_DEPTH + 6);
    compare_image("wrapped load");
    check_eq("wrap pulse cycles", rst_low_cycles - rst_base, 32'd1);
    end_test("zero count and wrap");

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/boot_pkg.sv
rtl/uart_rx.sv
rtl/ram_programmer.sv
rtl/mem_arbiter.sv
rtl/boot_ram.sv
rtl/boot_top.sv
dv/boot_props.sv
dv/tb_boot_top.sv

// File: Makefile
# Verilator build and run of the boot loader testbench

obj_dir/Vtb_boot_top: list.f $(wildcard rtl/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module tb_boot_top -f list.f

run: obj_dir/Vtb_boot_top
	obj_dir/Vtb_boot_top | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
